//--- src/bm_data_pkg.sv
// sizes assume 10-bit RAM addresses; a bin is found by a flat multiply of its number
package bm_data_pkg;

    // variables per bin also fix the clause width
    localparam int num_vars_a_bin = 8;
    localparam int def_clauses_a_bin = 8;

    localparam int bin_id_w = 10;
    localparam int clause_w = 2 * num_vars_a_bin;
    localparam int var_state_w = 19;
    localparam int clause_addr_w = 10;
    localparam int var_state_addr_w = 10;

    // all variable states of one bin with slot 0 in the low bits
    localparam int vs_bus_w = num_vars_a_bin * var_state_w;

    typedef logic [bin_id_w-1:0] bin_id_t;

    // two bits per variable
    typedef logic [clause_w-1:0] clause_t;

    typedef logic [var_state_w-1:0] var_state_t;

    typedef logic [clause_addr_w-1:0] clause_addr_t;

    typedef logic [var_state_addr_w-1:0] var_state_addr_t;

endpackage

//--- src/bm_ctrl_pkg.sv
// state codes are fixed so they can be read directly off a waveform
package bm_ctrl_pkg;

    typedef enum logic [2:0] {
        st_idle = 3'd0,
        st_load = 3'd1,
        st_core = 3'd2,
        st_wb   = 3'd3,
        st_done = 3'd4
    } ctrl_state_t;

endpackage

//--- src/bm_ctrl.sv
// start_bm_i counts only in idle; no back-pressure from the core or the movers
`timescale 1ns/1ps

module bm_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start_bm_i,
    input  bm_data_pkg::bin_id_t bin_num_i,
    input  logic                 done_load_i,
    input  logic                 done_core_i,
    input  logic                 done_wb_i,
    output logic                 start_load_o,
    output logic                 start_wb_o,
    output logic                 start_core_o,
    output logic                 done_bm_o,
    output logic                 busy_o,
    output bm_data_pkg::bin_id_t cur_bin_num_o
);

    bm_ctrl_pkg::ctrl_state_t state;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= bm_ctrl_pkg::st_idle;
            start_load_o <= 1'b0;
            start_core_o <= 1'b0;
            start_wb_o <= 1'b0;
            done_bm_o <= 1'b0;
        end else begin
            // every output here is a one-cycle pulse
            start_load_o <= 1'b0;
            start_core_o <= 1'b0;
            start_wb_o <= 1'b0;
            done_bm_o <= 1'b0;
            case (state)
                bm_ctrl_pkg::st_idle: begin
                    if (start_bm_i) begin
                        state <= bm_ctrl_pkg::st_load;
                        start_load_o <= 1'b1;
                    end
                end
                bm_ctrl_pkg::st_load: begin
                    if (done_load_i) begin
                        state <= bm_ctrl_pkg::st_core;
                        start_core_o <= 1'b1;
                    end
                end
                bm_ctrl_pkg::st_core: begin
                    if (done_core_i) begin
                        state <= bm_ctrl_pkg::st_wb;
                        start_wb_o <= 1'b1;
                    end
                end
                bm_ctrl_pkg::st_wb: begin
                    if (done_wb_i)
                        state <= bm_ctrl_pkg::st_done;
                end
                // one spare cycle lets the last store write land
                bm_ctrl_pkg::st_done: begin
                    state <= bm_ctrl_pkg::st_idle;
                    done_bm_o <= 1'b1;
                end
                default: state <= bm_ctrl_pkg::st_idle;
            endcase
        end
    end

    // bin number held for the whole run
    always_ff @(posedge clk) begin
        if (state == bm_ctrl_pkg::st_idle && start_bm_i)
            cur_bin_num_o <= bin_num_i;
    end

    assign busy_o = (state != bm_ctrl_pkg::st_idle);

endmodule

//--- src/bin_store.sv
// external writes apply only while not busy; read data arrives two cycles after the address
`timescale 1ns/1ps

module bin_store #(
    parameter int num_clauses_a_bin = bm_data_pkg::def_clauses_a_bin
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         busy_i,
    input  logic                         rd_en_i,
    input  bm_data_pkg::clause_addr_t    clause_raddr_i,
    input  bm_data_pkg::var_state_addr_t vs_raddr_i,
    input  logic                         wb_clause_we_i,
    input  bm_data_pkg::clause_addr_t    wb_clause_waddr_i,
    input  bm_data_pkg::clause_t         wb_clause_wdata_i,
    input  logic                         wb_vs_we_i,
    input  bm_data_pkg::var_state_addr_t wb_vs_waddr_i,
    input  bm_data_pkg::var_state_t      wb_vs_wdata_i,
    input  logic                         apply_ex_i,
    input  logic                         ram_we_c_ex_i,
    input  bm_data_pkg::clause_addr_t    ram_addr_c_ex_i,
    input  bm_data_pkg::clause_t         ram_din_c_ex_i,
    input  logic                         ram_we_vs_ex_i,
    input  bm_data_pkg::var_state_addr_t ram_addr_vs_ex_i,
    input  bm_data_pkg::var_state_t      ram_din_vs_ex_i,
    output bm_data_pkg::clause_t         clause_rdata_o,
    output bm_data_pkg::var_state_t      vs_rdata_o
);

    localparam int clause_depth = 2 ** bm_data_pkg::clause_addr_w;
    localparam int vs_full = 2 ** bm_data_pkg::var_state_addr_w;
    // var-state RAM only covers the bins the clause RAM can hold
    localparam int num_bins = clause_depth / num_clauses_a_bin;
    localparam int vs_need = num_bins * bm_data_pkg::num_vars_a_bin;
    localparam int vs_depth = (vs_need < vs_full) ? vs_need : vs_full;

    bm_data_pkg::clause_t         clause_ram [clause_depth];
    bm_data_pkg::var_state_t      vs_ram [vs_depth];

    bm_data_pkg::clause_addr_t    c_raddr_q;
    bm_data_pkg::var_state_addr_t vs_raddr_q;
    logic                         c_we_q;
    bm_data_pkg::clause_addr_t    c_waddr_q;
    bm_data_pkg::clause_t         c_wdata_q;
    logic                         vs_we_q;
    bm_data_pkg::var_state_addr_t vs_waddr_q;
    bm_data_pkg::var_state_t      vs_wdata_q;
    logic                         ex_ok;

    assign ex_ok = apply_ex_i && !busy_i;

    // read address parks at zero outside a load
    always_ff @(posedge clk) begin
        if (!rst) begin
            c_raddr_q <= '0;
            vs_raddr_q <= '0;
        end else if (rd_en_i) begin
            c_raddr_q <= clause_raddr_i;
            vs_raddr_q <= vs_raddr_i;
        end else begin
            c_raddr_q <= '0;
            vs_raddr_q <= '0;
        end
    end

    always_ff @(posedge clk) begin
        clause_rdata_o <= clause_ram[c_raddr_q];
        vs_rdata_o <= vs_ram[vs_raddr_q];
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            c_we_q <= 1'b0;
            vs_we_q <= 1'b0;
        end else begin
            c_we_q <= wb_clause_we_i || (ex_ok && ram_we_c_ex_i);
            vs_we_q <= wb_vs_we_i || (ex_ok && ram_we_vs_ex_i);
        end
    end

    // write-back wins the port over the preload
    always_ff @(posedge clk) begin
        c_waddr_q <= wb_clause_we_i ? wb_clause_waddr_i : ram_addr_c_ex_i;
        c_wdata_q <= wb_clause_we_i ? wb_clause_wdata_i : ram_din_c_ex_i;
        vs_waddr_q <= wb_vs_we_i ? wb_vs_waddr_i : ram_addr_vs_ex_i;
        vs_wdata_q <= wb_vs_we_i ? wb_vs_wdata_i : ram_din_vs_ex_i;
    end

    always_ff @(posedge clk) begin
        if (c_we_q)
            clause_ram[c_waddr_q] <= c_wdata_q;
        if (vs_we_q)
            vs_ram[vs_waddr_q] <= vs_wdata_q;
    end

endmodule

//--- src/bin_loader.sv
// relies on the store's two-cycle read; bin_num_i must stay stable for the whole load
`timescale 1ns/1ps

module bin_loader #(
    parameter int num_clauses_a_bin = bm_data_pkg::def_clauses_a_bin
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  start_load_i,
    input  bm_data_pkg::bin_id_t                  bin_num_i,
    input  bm_data_pkg::clause_t                  clause_rdata_i,
    input  bm_data_pkg::var_state_t               vs_rdata_i,
    output logic                                  rd_en_o,
    output bm_data_pkg::clause_addr_t             clause_raddr_o,
    output bm_data_pkg::var_state_addr_t          vs_raddr_o,
    output logic [num_clauses_a_bin-1:0]          wr_carray_o,
    output bm_data_pkg::clause_t                  clause_o,
    output logic [bm_data_pkg::num_vars_a_bin-1:0] wr_var_states_o,
    output bm_data_pkg::var_state_t               var_state_o,
    output logic                                  done_load_o
);

    localparam int num_vars = bm_data_pkg::num_vars_a_bin;
    // one pass covers the longer of the two arrays
    localparam int num_slots = (num_clauses_a_bin > num_vars) ? num_clauses_a_bin : num_vars;
    localparam int slot_w = $clog2(num_slots);

    logic              active;
    logic [slot_w-1:0] slot;
    logic [1:0]        vld_q;
    logic [slot_w-1:0] slot_q1;
    logic [slot_w-1:0] slot_q2;

    always_ff @(posedge clk) begin
        if (!rst) begin
            active <= 1'b0;
            slot <= '0;
            vld_q <= 2'b00;
        end else begin
            vld_q <= {vld_q[0], active};
            if (start_load_i) begin
                active <= 1'b1;
                slot <= '0;
            end else if (active) begin
                if (slot == slot_w'(num_slots - 1))
                    active <= 1'b0;
                slot <= slot + 1'b1;
            end
        end
    end

    // follows the address reg and the RAM reg in the store
    always_ff @(posedge clk) begin
        slot_q1 <= slot;
        slot_q2 <= slot_q1;
    end

    assign rd_en_o = active;
    assign clause_raddr_o = bm_data_pkg::clause_addr_t'(bin_num_i * num_clauses_a_bin)
                          + bm_data_pkg::clause_addr_t'(slot);
    assign vs_raddr_o = bm_data_pkg::var_state_addr_t'(bin_num_i * num_vars)
                      + bm_data_pkg::var_state_addr_t'(slot);

    always_comb begin
        wr_carray_o = '0;
        wr_var_states_o = '0;
        if (vld_q[1] && slot_q2 < num_clauses_a_bin)
            wr_carray_o[slot_q2] = 1'b1;
        if (vld_q[1] && slot_q2 < num_vars)
            wr_var_states_o[slot_q2] = 1'b1;
    end

    assign clause_o = clause_rdata_i;
    assign var_state_o = vs_rdata_i;
    assign done_load_o = vld_q[1] && (slot_q2 == slot_w'(num_slots - 1));

endmodule

//--- src/bin_writeback.sv
// engine arrays must answer reads in the same cycle; one slot per cycle, no stalls
`timescale 1ns/1ps

module bin_writeback #(
    parameter int num_clauses_a_bin = bm_data_pkg::def_clauses_a_bin
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  start_wb_i,
    input  bm_data_pkg::bin_id_t                  bin_num_i,
    input  bm_data_pkg::clause_t                  clause_i,
    input  logic [bm_data_pkg::vs_bus_w-1:0]      vars_states_i,
    output logic [num_clauses_a_bin-1:0]          rd_carray_o,
    output logic [bm_data_pkg::num_vars_a_bin-1:0] rd_var_states_o,
    output logic                                  clause_we_o,
    output bm_data_pkg::clause_addr_t             clause_waddr_o,
    output bm_data_pkg::clause_t                  clause_wdata_o,
    output logic                                  vs_we_o,
    output bm_data_pkg::var_state_addr_t          vs_waddr_o,
    output bm_data_pkg::var_state_t               vs_wdata_o,
    output logic                                  done_wb_o
);

    localparam int num_vars = bm_data_pkg::num_vars_a_bin;
    localparam int vs_w = bm_data_pkg::var_state_w;
    localparam int num_slots = (num_clauses_a_bin > num_vars) ? num_clauses_a_bin : num_vars;
    localparam int slot_w = $clog2(num_slots);

    logic              active;
    logic [slot_w-1:0] slot;
    logic              c_hit;
    logic              v_hit;
    logic              last;

    assign c_hit = active && (slot < num_clauses_a_bin);
    assign v_hit = active && (slot < num_vars);
    assign last = active && (slot == slot_w'(num_slots - 1));

    always_ff @(posedge clk) begin
        if (!rst) begin
            active <= 1'b0;
            slot <= '0;
        end else if (start_wb_i) begin
            active <= 1'b1;
            slot <= '0;
        end else if (active) begin
            if (last)
                active <= 1'b0;
            slot <= slot + 1'b1;
        end
    end

    always_comb begin
        rd_carray_o = '0;
        rd_var_states_o = '0;
        if (c_hit)
            rd_carray_o[slot] = 1'b1;
        if (v_hit)
            rd_var_states_o[slot] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            clause_we_o <= 1'b0;
            vs_we_o <= 1'b0;
            done_wb_o <= 1'b0;
        end else begin
            clause_we_o <= c_hit;
            vs_we_o <= v_hit;
            done_wb_o <= last;
        end
    end

    // request lands one cycle after the read strobe
    always_ff @(posedge clk) begin
        clause_waddr_o <= bm_data_pkg::clause_addr_t'(bin_num_i * num_clauses_a_bin)
                        + bm_data_pkg::clause_addr_t'(slot);
        clause_wdata_o <= clause_i;
        vs_waddr_o <= bm_data_pkg::var_state_addr_t'(bin_num_i * num_vars)
                    + bm_data_pkg::var_state_addr_t'(slot);
        vs_wdata_o <= vars_states_i[slot[2:0]*vs_w +: vs_w];
    end

endmodule

//--- src/bin_manager_top.sv
// engine must take a strobe every cycle; bins times clauses per bin must fit 10 address bits
`timescale 1ns/1ps

module bin_manager_top #(
    parameter int num_clauses_a_bin = bm_data_pkg::def_clauses_a_bin
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  start_bm_i,
    input  bm_data_pkg::bin_id_t                  bin_num_i,
    output logic                                  done_bm_o,
    output logic                                  start_core_o,
    input  logic                                  done_core_i,
    output bm_data_pkg::bin_id_t                  cur_bin_num_o,
    output logic [num_clauses_a_bin-1:0]          wr_carray_o,
    output bm_data_pkg::clause_t                  clause_o,
    output logic [bm_data_pkg::num_vars_a_bin-1:0] wr_var_states_o,
    output bm_data_pkg::var_state_t               var_state_o,
    output logic [num_clauses_a_bin-1:0]          rd_carray_o,
    output logic [bm_data_pkg::num_vars_a_bin-1:0] rd_var_states_o,
    input  bm_data_pkg::clause_t                  clause_i,
    input  logic [bm_data_pkg::vs_bus_w-1:0]      vars_states_i,
    input  logic                                  apply_ex_i,
    input  logic                                  ram_we_c_ex_i,
    input  bm_data_pkg::clause_addr_t             ram_addr_c_ex_i,
    input  bm_data_pkg::clause_t                  ram_din_c_ex_i,
    input  logic                                  ram_we_vs_ex_i,
    input  bm_data_pkg::var_state_addr_t          ram_addr_vs_ex_i,
    input  bm_data_pkg::var_state_t               ram_din_vs_ex_i
);

    logic                         start_load;
    logic                         done_load;
    logic                         start_wb;
    logic                         done_wb;
    logic                         busy;
    logic                         rd_en;
    bm_data_pkg::clause_addr_t    clause_raddr;
    bm_data_pkg::var_state_addr_t vs_raddr;
    bm_data_pkg::clause_t         clause_rdata;
    bm_data_pkg::var_state_t      vs_rdata;
    logic                         wb_clause_we;
    bm_data_pkg::clause_addr_t    wb_clause_waddr;
    bm_data_pkg::clause_t         wb_clause_wdata;
    logic                         wb_vs_we;
    bm_data_pkg::var_state_addr_t wb_vs_waddr;
    bm_data_pkg::var_state_t      wb_vs_wdata;

    bm_ctrl bm_ctrl_inst (
        .clk          (clk),
        .rst          (rst),
        .start_bm_i   (start_bm_i),
        .bin_num_i    (bin_num_i),
        .done_load_i  (done_load),
        .done_core_i  (done_core_i),
        .done_wb_i    (done_wb),
        .start_load_o (start_load),
        .start_wb_o   (start_wb),
        .start_core_o (start_core_o),
        .done_bm_o    (done_bm_o),
        .busy_o       (busy),
        .cur_bin_num_o(cur_bin_num_o)
    );

    bin_loader #(
        .num_clauses_a_bin(num_clauses_a_bin)
    ) bin_loader_inst (
        .clk            (clk),
        .rst            (rst),
        .start_load_i   (start_load),
        .bin_num_i      (cur_bin_num_o),
        .clause_rdata_i (clause_rdata),
        .vs_rdata_i     (vs_rdata),
        .rd_en_o        (rd_en),
        .clause_raddr_o (clause_raddr),
        .vs_raddr_o     (vs_raddr),
        .wr_carray_o    (wr_carray_o),
        .clause_o       (clause_o),
        .wr_var_states_o(wr_var_states_o),
        .var_state_o    (var_state_o),
        .done_load_o    (done_load)
    );

    bin_writeback #(
        .num_clauses_a_bin(num_clauses_a_bin)
    ) bin_writeback_inst (
        .clk            (clk),
        .rst            (rst),
        .start_wb_i     (start_wb),
        .bin_num_i      (cur_bin_num_o),
        .clause_i       (clause_i),
        .vars_states_i  (vars_states_i),
        .rd_carray_o    (rd_carray_o),
        .rd_var_states_o(rd_var_states_o),
        .clause_we_o    (wb_clause_we),
        .clause_waddr_o (wb_clause_waddr),
        .clause_wdata_o (wb_clause_wdata),
        .vs_we_o        (wb_vs_we),
        .vs_waddr_o     (wb_vs_waddr),
        .vs_wdata_o     (wb_vs_wdata),
        .done_wb_o      (done_wb)
    );

    bin_store #(
        .num_clauses_a_bin(num_clauses_a_bin)
    ) bin_store_inst (
        .clk              (clk),
        .rst              (rst),
        .busy_i           (busy),
        .rd_en_i          (rd_en),
        .clause_raddr_i   (clause_raddr),
        .vs_raddr_i       (vs_raddr),
        .wb_clause_we_i   (wb_clause_we),
        .wb_clause_waddr_i(wb_clause_waddr),
        .wb_clause_wdata_i(wb_clause_wdata),
        .wb_vs_we_i       (wb_vs_we),
        .wb_vs_waddr_i    (wb_vs_waddr),
        .wb_vs_wdata_i    (wb_vs_wdata),
        .apply_ex_i       (apply_ex_i),
        .ram_we_c_ex_i    (ram_we_c_ex_i),
        .ram_addr_c_ex_i  (ram_addr_c_ex_i),
        .ram_din_c_ex_i   (ram_din_c_ex_i),
        .ram_we_vs_ex_i   (ram_we_vs_ex_i),
        .ram_addr_vs_ex_i (ram_addr_vs_ex_i),
        .ram_din_vs_ex_i  (ram_din_vs_ex_i),
        .clause_rdata_o   (clause_rdata),
        .vs_rdata_o       (vs_rdata)
    );

endmodule

//--- verification/tb_clk_gen.sv
// free-running clock from time zero; active low reset released on a rising edge
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int period_ns = 8,
    parameter int reset_cycles = 2
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(period_ns / 2) clk_o = ~clk_o;
    end

    // reset held low for the first cycles
    initial begin
        rst_o = 1'b0;
        repeat (reset_cycles) @(posedge clk_o);
        rst_o <= 1'b1;
    end

endmodule

//--- verification/bin_manager_tb.sv
// runs at the default clauses per bin; engine model answers read strobes combinationally
`timescale 1ns/1ps

module bin_manager_tb;

    localparam int num_cl = bm_data_pkg::def_clauses_a_bin;
    localparam int num_vars = bm_data_pkg::num_vars_a_bin;
    localparam int vs_w = bm_data_pkg::var_state_w;
    localparam int num_slots = (num_cl > num_vars) ? num_cl : num_vars;
    localparam int wait_limit = 200;

    logic                                   clk;
    logic                                   rst;
    logic                                   start_bm;
    bm_data_pkg::bin_id_t                   bin_num;
    logic                                   done_bm;
    logic                                   start_core;
    logic                                   done_core;
    bm_data_pkg::bin_id_t                   cur_bin_num;
    logic [num_cl-1:0]                      wr_carray;
    bm_data_pkg::clause_t                   clause_out;
    logic [num_vars-1:0]                    wr_var_states;
    bm_data_pkg::var_state_t                var_state_out;
    logic [num_cl-1:0]                      rd_carray;
    logic [num_vars-1:0]                    rd_var_states;
    bm_data_pkg::clause_t                   clause_in;
    logic [bm_data_pkg::vs_bus_w-1:0]       vars_states_in;
    logic                                   apply_ex;
    logic                                   we_c_ex;
    bm_data_pkg::clause_addr_t              addr_c_ex;
    bm_data_pkg::clause_t                   din_c_ex;
    logic                                   we_vs_ex;
    bm_data_pkg::var_state_addr_t           addr_vs_ex;
    bm_data_pkg::var_state_t                din_vs_ex;

    // reference RAM contents and engine arrays
    bm_data_pkg::clause_t    ref_clause [1024];
    bm_data_pkg::var_state_t ref_vs [1024];
    bm_data_pkg::clause_t    core_clause [num_cl];
    bm_data_pkg::var_state_t core_vs [num_vars];
    bm_data_pkg::clause_t    got_clause [num_cl];
    bm_data_pkg::var_state_t got_vs [num_vars];
    int                      cnt_c [num_cl];
    int                      cnt_v [num_vars];
    int                      cnt_rc [num_cl];
    int                      cnt_rv [num_vars];

    int errors;
    int checks;
    int tests_run;
    int tests_failed;

    tb_clk_gen #(.period_ns(8), .reset_cycles(2)) clk_gen_inst (
        .clk_o(clk),
        .rst_o(rst)
    );

    bin_manager_top #(.num_clauses_a_bin(num_cl)) bin_manager_top_inst (
        .clk(clk), .rst(rst), .start_bm_i(start_bm), .bin_num_i(bin_num),
        .done_bm_o(done_bm), .start_core_o(start_core), .done_core_i(done_core),
        .cur_bin_num_o(cur_bin_num), .wr_carray_o(wr_carray), .clause_o(clause_out),
        .wr_var_states_o(wr_var_states), .var_state_o(var_state_out),
        .rd_carray_o(rd_carray), .rd_var_states_o(rd_var_states), .clause_i(clause_in),
        .vars_states_i(vars_states_in), .apply_ex_i(apply_ex), .ram_we_c_ex_i(we_c_ex),
        .ram_addr_c_ex_i(addr_c_ex), .ram_din_c_ex_i(din_c_ex), .ram_we_vs_ex_i(we_vs_ex),
        .ram_addr_vs_ex_i(addr_vs_ex), .ram_din_vs_ex_i(din_vs_ex)
    );

    // engine read side
    always_comb begin
        clause_in = '0;
        for (int k = 0; k < num_cl; k++)
            if (rd_carray[k])
                clause_in = core_clause[k];
    end

    always_comb begin
        for (int j = 0; j < num_vars; j++)
            vars_states_in[j*vs_w +: vs_w] = core_vs[j];
    end

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_quiet(input int n, input string what);
        int activity;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            activity = $countones({wr_carray, wr_var_states, rd_carray, rd_var_states,
                                   start_core, done_bm});
            check_eq(activity, 0, what);
        end
    endtask

    task automatic preload_bin(input int b);
        bm_data_pkg::clause_t    cdata;
        bm_data_pkg::var_state_t vdata;
        for (int i = 0; i < num_slots; i++) begin
            cdata = bm_data_pkg::clause_t'($urandom);
            vdata = bm_data_pkg::var_state_t'($urandom);
            @(posedge clk);
            apply_ex <= 1'b1;
            we_c_ex <= (i < num_cl);
            we_vs_ex <= (i < num_vars);
            addr_c_ex <= bm_data_pkg::clause_addr_t'(b * num_cl + i % num_cl);
            din_c_ex <= cdata;
            addr_vs_ex <= bm_data_pkg::var_state_addr_t'(b * num_vars + i % num_vars);
            din_vs_ex <= vdata;
            if (i < num_cl)
                ref_clause[b * num_cl + i] = cdata;
            if (i < num_vars)
                ref_vs[b * num_vars + i] = vdata;
        end
        @(posedge clk);
        apply_ex <= 1'b0;
        we_c_ex <= 1'b0;
        we_vs_ex <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // one clock of stimulus and settling at the falling edge
    task automatic step_cycle(input bit ex_on, input bit core_pulse, input bit stray,
                              input int stray_bin);
        @(posedge clk);
        start_bm <= stray;
        bin_num <= bm_data_pkg::bin_id_t'(stray_bin);
        done_core <= core_pulse;
        apply_ex <= ex_on;
        we_c_ex <= ex_on;
        we_vs_ex <= ex_on;
        // blocked writes always aim at bin 3
        addr_c_ex <= bm_data_pkg::clause_addr_t'(3 * num_cl + $urandom_range(0, num_cl - 1));
        din_c_ex <= bm_data_pkg::clause_t'($urandom);
        addr_vs_ex <= bm_data_pkg::var_state_addr_t'(3 * num_vars + $urandom_range(0, 7));
        din_vs_ex <= bm_data_pkg::var_state_t'($urandom);
        @(negedge clk);
    endtask

    task automatic capture_strobes();
        for (int k = 0; k < num_cl; k++)
            if (wr_carray[k]) begin
                cnt_c[k]++;
                got_clause[k] = clause_out;
            end
        for (int j = 0; j < num_vars; j++)
            if (wr_var_states[j]) begin
                cnt_v[j]++;
                got_vs[j] = var_state_out;
            end
    endtask

    task automatic count_reads();
        for (int k = 0; k < num_cl; k++)
            if (rd_carray[k])
                cnt_rc[k]++;
        for (int j = 0; j < num_vars; j++)
            if (rd_var_states[j])
                cnt_rv[j]++;
    endtask

    task automatic check_load(input int b);
        for (int k = 0; k < num_cl; k++) begin
            check_eq(cnt_c[k], 1, $sformatf("bin %0d clause slot %0d writes", b, k));
            check_eq(got_clause[k], ref_clause[b * num_cl + k],
                     $sformatf("bin %0d clause slot %0d", b, k));
        end
        for (int j = 0; j < num_vars; j++) begin
            check_eq(cnt_v[j], 1, $sformatf("bin %0d var slot %0d writes", b, j));
            check_eq(got_vs[j], ref_vs[b * num_vars + j],
                     $sformatf("bin %0d var slot %0d", b, j));
        end
        check_eq(cur_bin_num, b, "cur_bin_num_o");
    endtask

    task automatic check_reads(input int b);
        for (int k = 0; k < num_cl; k++)
            check_eq(cnt_rc[k], 1, $sformatf("bin %0d clause slot %0d reads", b, k));
        for (int j = 0; j < num_vars; j++)
            check_eq(cnt_rv[j], 1, $sformatf("bin %0d var slot %0d reads", b, j));
    endtask

    task automatic run_bin(input int b, input bit new_data, input bit hold_ex, input bit stray);
        int  cycles;
        int  core_wait;
        bit  ex_stop;
        for (int k = 0; k < num_cl; k++) begin
            cnt_c[k] = 0;
            cnt_rc[k] = 0;
        end
        for (int j = 0; j < num_vars; j++) begin
            cnt_v[j] = 0;
            cnt_rv[j] = 0;
        end
        ex_stop = 1'b0;
        @(posedge clk);
        start_bm <= 1'b1;
        bin_num <= bm_data_pkg::bin_id_t'(b);
        cycles = 0;
        while (!start_core && cycles < wait_limit) begin
            step_cycle(hold_ex, 1'b0, stray && cycles == 2, stray ? (b + 1) % 4 : b);
            capture_strobes();
            cycles++;
        end
        assert (start_core) else begin
            $display("Timeout: start_core_o never rose during the run of bin %0d", b);
            errors++;
        end
        if (!start_core)
            return;
        check_load(b);
        for (int k = 0; k < num_cl; k++)
            core_clause[k] = new_data ? bm_data_pkg::clause_t'($urandom) : got_clause[k];
        for (int j = 0; j < num_vars; j++)
            core_vs[j] = new_data ? bm_data_pkg::var_state_t'($urandom) : got_vs[j];
        core_wait = $urandom_range(0, 5);
        cycles = 0;
        while (!done_bm && cycles < wait_limit) begin
            step_cycle(hold_ex && !ex_stop, cycles == core_wait, 1'b0, b);
            count_reads();
            // stop external writes once the last read strobe shows
            if (rd_carray[num_cl-1] || rd_var_states[num_vars-1])
                ex_stop = 1'b1;
            cycles++;
        end
        assert (done_bm) else begin
            $display("Timeout: done_bm_o never rose during the run of bin %0d", b);
            errors++;
        end
        if (done_bm)
            check_reads(b);
        for (int k = 0; k < num_cl; k++)
            ref_clause[b * num_cl + k] = core_clause[k];
        for (int j = 0; j < num_vars; j++)
            ref_vs[b * num_vars + j] = core_vs[j];
        step_cycle(1'b0, 1'b0, 1'b0, b);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors != errs_before)
            tests_failed++;
        $display("test %s: %0d errors", name, errors - errs_before);
    endtask

    initial begin
        int e0;
        int n;
        start_bm = 1'b0;
        bin_num = '0;
        done_core = 1'b0;
        apply_ex = 1'b0;
        we_c_ex = 1'b0;
        addr_c_ex = '0;
        din_c_ex = '0;
        we_vs_ex = 1'b0;
        addr_vs_ex = '0;
        din_vs_ex = '0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        void'($urandom(3));
        for (int k = 0; k < num_cl; k++)
            core_clause[k] = '0;
        for (int j = 0; j < num_vars; j++)
            core_vs[j] = '0;

        e0 = errors;
        n = 0;
        while (!rst && n < 20) begin
            @(negedge clk);
            n++;
        end
        assert (rst) else begin
            $display("Timeout: reset was never released");
            errors++;
        end
        check_quiet(10, "outputs idle after reset");
        report_test("reset_state", e0);

        e0 = errors;
        for (int b = 0; b < 4; b++)
            preload_bin(b);
        run_bin(2, 1'b0, 1'b0, 1'b0);
        report_test("preload_and_load", e0);

        e0 = errors;
        run_bin(2, 1'b1, 1'b0, 1'b0);
        run_bin(2, 1'b0, 1'b0, 1'b0);
        run_bin(1, 1'b0, 1'b0, 1'b0);
        report_test("write_back", e0);

        e0 = errors;
        run_bin(0, 1'b0, 1'b1, 1'b0);
        run_bin(3, 1'b0, 1'b0, 1'b0);
        preload_bin(3);
        run_bin(3, 1'b0, 1'b0, 1'b0);
        report_test("external_writes_while_busy", e0);

        e0 = errors;
        run_bin(0, 1'b1, 1'b0, 1'b0);
        run_bin(1, 1'b1, 1'b0, 1'b0);
        run_bin(3, 1'b1, 1'b0, 1'b1);
        check_quiet(20, "no run after ignored start");
        report_test("back_to_back", e0);

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- list.f
src/bm_data_pkg.sv
src/bm_ctrl_pkg.sv
src/bm_ctrl.sv
src/bin_store.sv
src/bin_loader.sv
src/bin_writeback.sv
src/bin_manager_top.sv
verification/tb_clk_gen.sv
verification/bin_manager_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the bin manager testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module bin_manager_tb -o sim_bm > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_bm > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" sim.log; then
    exit 1
fi
if ! grep -q "Regression passed" sim.log; then
    echo "no result found in sim.log"
    exit 1
fi
exit 0
